//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - hw/fetch_pkg.sv
  - hw/fetch_pc_if.sv
  - hw/fetch_ctrl_regs.sv
  - hw/fetch_stage1.sv
  - hw/imem_port.sv
  - hw/fetch_stage2.sv
  - hw/fetch_frontend_top.sv
  - target: simulation
    files:
      - verification/fetch_frontend_tb.sv

//--- fetch_frontend.f
hw/fetch_pkg.sv
hw/fetch_pc_if.sv
hw/fetch_ctrl_regs.sv
hw/fetch_stage1.sv
hw/imem_port.sv
hw/fetch_stage2.sv
hw/fetch_frontend_top.sv
verification/fetch_frontend_tb.sv

//--- hw/fetch_ctrl_regs.sv
`timescale 1ns/1ps

module fetch_ctrl_regs (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic               cfg_we_i,
    input  logic               cfg_sel_i,
    input  fetch_pkg::pc_t     cfg_wdata_i,

    output fetch_pkg::pc_t     boot_addr_o,
    output fetch_pkg::wait_t   wait_cycles_o
);

    fetch_pkg::pc_t   boot_addr_q;
    fetch_pkg::wait_t wait_cycles_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            boot_addr_q   <= fetch_pkg::BOOT_ADDR_RST;
            wait_cycles_q <= fetch_pkg::WAIT_RST;
        end
        else if (cfg_we_i) begin
            if (cfg_sel_i == fetch_pkg::REG_BOOT) begin
                boot_addr_q <= cfg_wdata_i;
            end
            else if (cfg_sel_i == fetch_pkg::REG_WAIT) begin
                wait_cycles_q <= fetch_pkg::wait_t'(cfg_wdata_i); // Low bits only.
            end
        end
    end

    assign boot_addr_o   = boot_addr_q;
    assign wait_cycles_o = wait_cycles_q;

    // A write during reset would be lost, so the host must wait for release.
    assert property (@(posedge clk_i) !rstn_i |-> !cfg_we_i)
        else $error("fetch_ctrl_regs: cfg write while reset is active");

endmodule

//--- hw/fetch_frontend_top.sv
`timescale 1ns/1ps

module fetch_frontend_top (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  logic                stall_i,
    input  logic                redirect_i,
    input  fetch_pkg::pc_t      redirect_pc_i,

    input  logic                cfg_we_i,
    input  logic                cfg_sel_i,
    input  fetch_pkg::pc_t      cfg_wdata_i,

    output logic                instr_valid_o,
    output fetch_pkg::instr_t   instr_o,
    output fetch_pkg::pc_t      instr_pc_o,
    input  logic                instr_ready_i
);

    fetch_pkg::pc_t    boot_addr;
    fetch_pkg::wait_t  wait_cycles;
    fetch_pkg::pc_t    imem_addr;
    logic              imem_req;
    logic              imem_gnt;
    logic              imem_rvalid;
    fetch_pkg::instr_t imem_rdata;

    fetch_pc_if pc_if ();                              // Stage one to stage two handover.

    fetch_ctrl_regs u_ctrl_regs (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_sel_i     (cfg_sel_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .boot_addr_o   (boot_addr),
        .wait_cycles_o (wait_cycles)
    );

    fetch_stage1 u_stage1 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .boot_addr_i   (boot_addr),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_gnt_i    (imem_gnt),
        .imem_addr_o   (imem_addr),
        .imem_req_o    (imem_req),
        .s2            (pc_if.s1)
    );

    imem_port u_imem (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .wait_cycles_i (wait_cycles),
        .req_i         (imem_req),
        .addr_i        (imem_addr),
        .gnt_o         (imem_gnt),
        .rvalid_o      (imem_rvalid),
        .rdata_o       (imem_rdata)
    );

    fetch_stage2 u_stage2 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (redirect_i),                   // Redirect also flushes stage two.
        .s1            (pc_if.s2),
        .rvalid_i      (imem_rvalid),
        .rdata_i       (imem_rdata),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_ready_i (instr_ready_i)
    );

endmodule

//--- hw/fetch_pc_if.sv
`timescale 1ns/1ps

interface fetch_pc_if;

    fetch_pkg::pc_t pc;                                // PC of the last accepted request.
    logic           pc_valid;                          // Handover register holds a PC.
    logic           pc_ready;                          // Stage two can take the handover.
    logic           req_done;                          // Memory accepted a request this cycle.

    modport s1 (
        output pc,
        output pc_valid,
        output req_done,
        input  pc_ready
    );

    modport s2 (
        input  pc,
        input  pc_valid,
        input  req_done,
        output pc_ready
    );

endinterface

//--- hw/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] pc_t;                         // Program counter and memory address.
    typedef logic [31:0] instr_t;                      // Instruction word.
    typedef logic [3:0]  wait_t;                       // Memory wait cycle count.

    localparam pc_t   BOOT_ADDR_RST = 32'h0000_1000;   // Boot address after reset.
    localparam wait_t WAIT_RST      = 4'd2;            // Memory wait cycles after reset.
    localparam pc_t   PC_STEP       = 32'd4;           // One word per fetch.

    // The memory returns A ^ IMEM_KEY for an aligned address A.
    localparam pc_t   IMEM_KEY      = 32'h5a5a_3c3c;

    localparam logic  REG_BOOT      = 1'b0;            // Selects the boot address register.
    localparam logic  REG_WAIT      = 1'b1;            // Selects the wait count register.

    // Stage two output slot and pending response tracking.
    typedef enum logic [1:0] {
        S2_IDLE,                                       // Slot empty, nothing in flight.
        S2_WAIT,                                       // Slot empty, one response pending.
        S2_HOLD                                        // Slot full until the core takes it.
    } s2_state_e;

endpackage

//--- hw/fetch_stage1.sv
`timescale 1ns/1ps

module fetch_stage1 (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  fetch_pkg::pc_t     boot_addr_i,

    input  logic               stall_i,
    input  logic               redirect_i,
    input  fetch_pkg::pc_t     redirect_pc_i,

    input  logic               imem_gnt_i,
    output fetch_pkg::pc_t     imem_addr_o,
    output logic               imem_req_o,

    fetch_pc_if.s1             s2
);

    fetch_pkg::pc_t pc_q;                              // Next PC to request.
    fetch_pkg::pc_t pc_d;

    fetch_pkg::pc_t ho_pc_q;                           // PC handed to stage two.
    fetch_pkg::pc_t ho_pc_d;
    logic           ho_valid_q;
    logic           ho_valid_d;

    fetch_pkg::pc_t pc_sel;
    fetch_pkg::pc_t pc_cmb;                            // PC used for this cycle's request.
    logic           hold;
    logic           req;
    logic           accept;

    always_comb begin
        pc_sel = redirect_i ? redirect_pc_i : pc_q;    // Redirect bypasses the PC register.
        pc_cmb = {pc_sel[31:2], 2'b00};

        // Handover still waiting on stage two, so no room for another PC.
        hold   = ho_valid_q && !s2.pc_ready && !redirect_i;
        req    = !stall_i && !hold;
        accept = req && imem_gnt_i;

        pc_d       = pc_cmb;
        ho_pc_d    = ho_pc_q;
        ho_valid_d = ho_valid_q;

        if (ho_valid_q && s2.pc_ready) begin           // Stage two takes the handover.
            ho_valid_d = 1'b0;
        end

        if (redirect_i) begin                          // Old path PC is no longer wanted.
            ho_valid_d = 1'b0;
        end

        if (accept) begin                              // Memory took the request.
            ho_pc_d    = pc_cmb;
            ho_valid_d = 1'b1;
            pc_d       = pc_cmb + fetch_pkg::PC_STEP;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pc_q       <= boot_addr_i;                 // Value at reset release wins.
            ho_valid_q <= 1'b0;
        end
        else begin
            pc_q       <= pc_d;
            ho_valid_q <= ho_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        ho_pc_q <= ho_pc_d;
    end

    assign imem_addr_o = pc_cmb;
    assign imem_req_o  = req;

    assign s2.pc       = ho_pc_q;
    assign s2.pc_valid = ho_valid_q;
    assign s2.req_done = accept;

    // The request address is the PC itself, never a truncated one.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        imem_req_o |-> (pc_sel[1:0] == 2'b00))
        else $error("fetch_stage1: request PC %h is not word aligned", pc_sel);

endmodule

//--- hw/fetch_stage2.sv
`timescale 1ns/1ps

module fetch_stage2 (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  logic                flush_i,

    fetch_pc_if.s2              s1,

    input  logic                rvalid_i,
    input  fetch_pkg::instr_t   rdata_i,

    output logic                instr_valid_o,
    output fetch_pkg::instr_t   instr_o,
    output fetch_pkg::pc_t      instr_pc_o,
    input  logic                instr_ready_i
);

    fetch_pkg::s2_state_e state_q;
    fetch_pkg::s2_state_e state_d;

    logic              drop_q;                         // Next response is from the old path.
    logic              drop_d;
    logic              capture;

    fetch_pkg::instr_t instr_q;
    fetch_pkg::pc_t    pc_q;

    always_comb begin
        state_d = state_q;
        drop_d  = drop_q;
        capture = 1'b0;

        unique case (state_q)
            fetch_pkg::S2_IDLE: begin
                if (s1.req_done) begin
                    state_d = fetch_pkg::S2_WAIT;
                end
            end
            fetch_pkg::S2_WAIT: begin
                if (rvalid_i && s1.pc_valid && !drop_q) begin // Pair the word with its PC.
                    state_d = fetch_pkg::S2_HOLD;
                    capture = 1'b1;
                end
            end
            fetch_pkg::S2_HOLD: begin
                if (instr_ready_i) begin               // Back to back if a request went out.
                    state_d = s1.req_done ? fetch_pkg::S2_WAIT : fetch_pkg::S2_IDLE;
                end
            end
            default: begin
                state_d = fetch_pkg::S2_IDLE;
            end
        endcase

        if (rvalid_i && drop_q) begin                  // Stale response is thrown away.
            drop_d = 1'b0;
        end

        if (flush_i) begin
            capture = 1'b0;
            if (state_q == fetch_pkg::S2_WAIT && !rvalid_i) begin
                drop_d = 1'b1;                         // Old response still on its way.
            end
            state_d = s1.req_done ? fetch_pkg::S2_WAIT : fetch_pkg::S2_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= fetch_pkg::S2_IDLE;
            drop_q  <= 1'b0;
        end
        else begin
            state_q <= state_d;
            drop_q  <= drop_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            instr_q <= rdata_i;
            pc_q    <= s1.pc;
        end
    end

    // Only take a PC when the slot will be free for its response.
    assign s1.pc_ready = (state_q == fetch_pkg::S2_IDLE) ||
                         (state_q == fetch_pkg::S2_HOLD && instr_ready_i);

    assign instr_valid_o = (state_q == fetch_pkg::S2_HOLD);
    assign instr_o       = instr_q;
    assign instr_pc_o    = pc_q;

    // Output must not change under back-pressure.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_o && !instr_ready_i && !flush_i) |=>
            (instr_valid_o && $stable(instr_o) && $stable(instr_pc_o)))
        else $error("fetch_stage2: instr_o changed while stalled, now %h", instr_o);

endmodule

//--- hw/imem_port.sv
`timescale 1ns/1ps

module imem_port (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  fetch_pkg::wait_t    wait_cycles_i,

    input  logic                req_i,
    input  fetch_pkg::pc_t      addr_i,
    output logic                gnt_o,

    output logic                rvalid_o,
    output fetch_pkg::instr_t   rdata_o
);

    logic              busy_q;                         // One request outstanding.
    logic              rvalid_q;
    fetch_pkg::wait_t  cnt_q;                          // Remaining wait cycles.
    fetch_pkg::pc_t    addr_q;
    fetch_pkg::instr_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q   <= 1'b0;
            rvalid_q <= 1'b0;
            cnt_q    <= '0;
        end
        else if (!busy_q) begin
            if (req_i) begin                           // Grant is high while idle.
                busy_q <= 1'b1;
                cnt_q  <= wait_cycles_i;
            end
        end
        else if (rvalid_q) begin                       // Response pulse ends here.
            busy_q   <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else if (cnt_q == '0) begin
            rvalid_q <= 1'b1;
        end
        else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Address and data carry no reset.
    always_ff @(posedge clk_i) begin
        if (!busy_q && req_i) begin
            addr_q <= {addr_i[31:2], 2'b00};
        end
        if (busy_q && !rvalid_q && cnt_q == '0) begin
            rdata_q <= addr_q ^ fetch_pkg::IMEM_KEY;   // Fixed content rule.
        end
    end

    assign gnt_o    = !busy_q;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    // A response needs an accepted request and lasts a single cycle.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(rvalid_o) |-> ($past(busy_q) && !gnt_o) ##1 !rvalid_o)
        else $error("imem_port: rvalid without outstanding request");

endmodule

//--- verification/fetch_frontend_tb.sv
`timescale 1ns/1ps

module fetch_frontend_tb;

    localparam int T_BOOT      = 60;                   // Cycle budget of each test.
    localparam int T_STREAM    = 600;
    localparam int T_BACKPRES  = 700;
    localparam int T_REDIRECT  = 300;
    localparam int T_CONFIG    = 500;
    localparam int T_STALL     = 200;
    localparam int BUDGET      = T_BOOT + T_STREAM + T_BACKPRES + T_REDIRECT + T_CONFIG + T_STALL;
    localparam int WATCHDOG_NS = 20 * BUDGET * 100;

    logic              clk_i         = 1'b0;
    logic              rstn_i        = 1'b0;
    logic              stall_i       = 1'b0;
    logic              redirect_i    = 1'b0;
    fetch_pkg::pc_t    redirect_pc_i = '0;
    logic              cfg_we_i      = 1'b0;
    logic              cfg_sel_i     = 1'b0;
    fetch_pkg::pc_t    cfg_wdata_i   = '0;
    logic              instr_ready_i = 1'b0;
    logic              instr_valid_o;
    fetch_pkg::instr_t instr_o;
    fetch_pkg::pc_t    instr_pc_o;

    integer seed       = 32'ha2a2067a;
    int     rnd;
    int     ready_mode = 0;                            // 0 high, 1 half the time, 2 mostly low.
    int     stall_mode = 0;                            // 0 off, 1 random pulses, 2 held high.

    fetch_pkg::pc_t   exp_pc;                          // Next PC the core should see.
    fetch_pkg::pc_t   boot_reg   = fetch_pkg::BOOT_ADDR_RST;
    fetch_pkg::wait_t wait_reg   = fetch_pkg::WAIT_RST;
    int               accept_cnt = 0;
    int               gap_cnt    = 0;                  // Edges since the last accepted instruction.
    logic             gap_ok     = 1'b0;
    int               stall_run  = 0;
    int               err_count  = 0;
    int               err_mark   = 0;
    int               tests_run  = 0;
    int               tests_failed = 0;
    int               idx;

    fetch_frontend_top DUT (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        rnd = $random(seed);
        case (ready_mode)
            0:       instr_ready_i <= 1'b1;
            1:       instr_ready_i <= rnd[0];
            default: instr_ready_i <= (rnd[3:2] == 2'b00);
        endcase
        case (stall_mode)
            0:       stall_i <= 1'b0;
            1:       stall_i <= (rnd[7:5] == 3'b000);
            default: stall_i <= 1'b1;
        endcase
    end

    // Reference PC model and the counters behind the timing checks.
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            exp_pc    <= boot_reg;                     // Fetch restarts at the boot register.
            boot_reg  <= fetch_pkg::BOOT_ADDR_RST;
            wait_reg  <= fetch_pkg::WAIT_RST;
            gap_ok    <= 1'b0;
            gap_cnt   <= 0;
            stall_run <= 0;
        end
        else begin
            if (cfg_we_i && cfg_sel_i == fetch_pkg::REG_BOOT) begin
                boot_reg <= cfg_wdata_i;
            end
            if (cfg_we_i && cfg_sel_i == fetch_pkg::REG_WAIT) begin
                wait_reg <= fetch_pkg::wait_t'(cfg_wdata_i);
            end
            if (instr_valid_o && instr_ready_i) begin
                exp_pc     <= exp_pc + fetch_pkg::PC_STEP;
                accept_cnt <= accept_cnt + 1;
                gap_cnt    <= 1;
                gap_ok     <= !redirect_i && !stall_i && !cfg_we_i;
            end
            else begin
                gap_cnt <= (gap_cnt < 255) ? gap_cnt + 1 : gap_cnt;
                if (!instr_ready_i || redirect_i || stall_i || cfg_we_i) begin
                    gap_ok <= 1'b0;
                end
            end
            if (redirect_i) begin
                exp_pc <= redirect_pc_i;               // New path starts at the redirect PC.
            end
            stall_run <= (stall_i && instr_ready_i) ? stall_run + 1 : 0;
        end
    end

    assert property (@(posedge clk_i) !rstn_i |=> (!instr_valid_o && !DUT.imem_rvalid))
        else begin
            $display("[ERROR] instr_valid_o/imem_rvalid after reset: got %h/%h, expected 0/0",
                     $sampled(instr_valid_o), $sampled(DUT.imem_rvalid));
            err_count = err_count + 1;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_o && instr_ready_i) |-> (instr_pc_o == exp_pc))
        else begin
            $display("[ERROR] instr_pc_o: got %h, expected %h",
                     $sampled(instr_pc_o), $sampled(exp_pc));
            err_count = err_count + 1;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        instr_valid_o |-> (instr_o == (exp_pc ^ fetch_pkg::IMEM_KEY)))
        else begin
            $display("[ERROR] instr_o: got %h, expected %h",
                     $sampled(instr_o), $sampled(exp_pc) ^ fetch_pkg::IMEM_KEY);
            err_count = err_count + 1;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_o && !instr_ready_i && !redirect_i) |=>
            (instr_valid_o && $stable(instr_o) && $stable(instr_pc_o)))
        else begin
            $display("Held instruction changed or vanished while the core was not ready.");
            err_count = err_count + 1;
        end

    // Request and handshake share an edge at best, then wait+1 cycles and one capture edge.
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (instr_valid_o && instr_ready_i && gap_ok) |-> (gap_cnt >= int'(wait_reg) + 3))
        else begin
            $display("[ERROR] accept gap: got %h cycles, expected at least %h",
                     $sampled(gap_cnt), $sampled(int'(wait_reg)) + 3);
            err_count = err_count + 1;
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (stall_run > int'(wait_reg) + 5) |-> !instr_valid_o)
        else begin
            $display("New instruction appeared %0d cycles into a stall.", $sampled(stall_run));
            err_count = err_count + 1;
        end

    task automatic wait_accepts(input int n);
        int target;
        target = accept_cnt + n;
        while (accept_cnt < target) begin
            @(posedge clk_i);
        end
    endtask

    task automatic cfg_write(input logic sel, input fetch_pkg::pc_t data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_sel_i   <= sel;
        cfg_wdata_i <= data;
        @(posedge clk_i);
        cfg_we_i    <= 1'b0;
    endtask

    task automatic redirect_to(input fetch_pkg::pc_t pc);
        @(posedge clk_i);
        redirect_i    <= 1'b1;
        redirect_pc_i <= pc;
        @(posedge clk_i);
        redirect_i    <= 1'b0;
    endtask

    task automatic reset_pulse();
        @(posedge clk_i);
        rstn_i <= 1'b0;                                // One edge only, so the new boot sticks.
        @(posedge clk_i);
        rstn_i <= 1'b1;
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = err_count - err_mark;
        tests_run = tests_run + 1;
        if (fails == 0) begin
            $display("Test %0d %s: ok, %0d accepted so far", tests_run, name, accept_cnt);
        end
        else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d %s: %0d errors", tests_run, name, fails);
        end
        err_mark = err_count;
    endtask

    initial begin
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        wait_accepts(1);
        end_test("boot fetch");

        ready_mode <= 1;
        stall_mode <= 1;
        wait_accepts(40);
        end_test("sequential stream");

        ready_mode <= 2;
        stall_mode <= 0;
        wait_accepts(20);
        end_test("back-pressure hold");

        ready_mode <= 0;
        for (idx = 0; idx < 4; idx = idx + 1) begin
            wait_accepts(1);
            repeat (1 + idx) @(posedge clk_i);         // Hits wait, response and hold cycles.
            redirect_to(32'h0002_0000 + 32'h100 * idx);
            wait_accepts(3);
        end
        end_test("redirect");

        cfg_write(fetch_pkg::REG_BOOT, 32'h0000_8000);
        reset_pulse();
        wait_accepts(4);
        cfg_write(fetch_pkg::REG_WAIT, 32'd0);
        wait_accepts(10);
        cfg_write(fetch_pkg::REG_WAIT, 32'd7);
        wait_accepts(10);
        end_test("config writes");

        stall_mode <= 2;
        repeat (40) @(posedge clk_i);
        stall_mode <= 0;
        wait_accepts(5);
        end_test("stall and resume");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the front end stopped delivering.", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule
